/* clk_div_chain.sv */
module clk_div_chain (
  input  logic clkp,
  input  logic rstxo,
  input  logic tick,
  input  logic locked,
  output logic div32
);

  localparam int STAGES = 5;

  logic              lock_s1;
  logic              lock_s2;
  logic [STAGES-1:0] stg;
  logic [STAGES-2:0] stg_d1;
  logic [STAGES-2:0] rise;

  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      lock_s1 <= 1'b0;
      lock_s2 <= 1'b0;
    end else begin
      lock_s1 <= locked;
      lock_s2 <= lock_s1;
    end
  end

  assign rise = stg[STAGES-2:0] & ~stg_d1;

  // Stage 0 toggles every tick, each later stage on a rise of the one before.
  always_ff @(posedge clkp or negedge lock_s2) begin
    if (!lock_s2) begin
      stg    <= '0;
      stg_d1 <= '0;
    end else if (tick) begin
      stg_d1 <= stg[STAGES-2:0];
      stg    <= stg ^ {rise, 1'b1};
    end
  end

  assign div32 = stg[STAGES-1];

endmodule

/* drp_pkg.sv */
`include "pll_ctrl_defines.svh"

package drp_pkg;

  // Request from the sequencer, rst_pll rides along.
  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [`DRP_ADDR_W-1:0] addr;
    logic [`DRP_DATA_W-1:0] wdata;
    logic                   rst_pll;
  } drp_req_t;

  typedef struct packed {
    logic                   rdy;
    logic [`DRP_DATA_W-1:0] rdata;
    logic                   locked;
  } drp_rsp_t;

  // Output-divide register, d = hi + lo.
  typedef struct packed {
    logic [3:0] rsvd;
    logic [5:0] lo;
    logic [5:0] hi;
  } div_reg_t;

endpackage

/* list.f */
+incdir+.
drp_pkg.sv
ui_pkg.sv
setting_ctrl.sv
pll_drp_seq.sv
pll_model.sv
clk_div_chain.sv
pll_ctrl_top.sv
tb_pll_ctrl.sv

/* pll_ctrl_defines.svh */
`ifndef PLL_CTRL_DEFINES_SVH
`define PLL_CTRL_DEFINES_SVH

// Width of the user setting.
`define SETTING_W 4

// DRP bus widths.
`define DRP_ADDR_W 5
`define DRP_DATA_W 16

// Output-divide register address.
`define DRP_DIV_ADDR 5'h08

// Model timing in clkp cycles.
`define LOCK_CYCLES 64
`define DRP_LAT 2

`endif

/* pll_ctrl_top.sv */
module pll_ctrl_top (
  input  logic            clkp,
  input  logic            rstxp,
  input  logic            btn_up,
  input  logic            btn_dn,
  output ui_pkg::digits_t digits,
  output logic            pll_lock,
  output logic            div32,
  output logic            rstxo
);

  ui_pkg::setting_t  setting;
  logic              change;
  drp_pkg::drp_req_t drp_req;
  drp_pkg::drp_rsp_t drp_rsp;
  logic              tick;

  setting_ctrl u_setting_ctrl (
    .clkp    (clkp),
    .rstxp   (rstxp),
    .btn_up  (btn_up),
    .btn_dn  (btn_dn),
    .rstxo   (rstxo),
    .setting (setting),
    .change  (change),
    .digits  (digits)
  );

  pll_drp_seq u_pll_drp_seq (
    .clkp    (clkp),
    .rstxo   (rstxo),
    .setting (setting),
    .change  (change),
    .req     (drp_req),
    .rsp     (drp_rsp)
  );

  pll_model u_pll_model (
    .clkp  (clkp),
    .rstxo (rstxo),
    .req   (drp_req),
    .rsp   (drp_rsp),
    .tick  (tick)
  );

  clk_div_chain u_clk_div_chain (
    .clkp   (clkp),
    .rstxo  (rstxo),
    .tick   (tick),
    .locked (drp_rsp.locked),
    .div32  (div32)
  );

  assign pll_lock = drp_rsp.locked;

endmodule

/* pll_drp_seq.sv */
`include "pll_ctrl_defines.svh"

module pll_drp_seq (
  input  logic              clkp,
  input  logic              rstxo,
  input  ui_pkg::setting_t  setting,
  input  logic              change,
  output drp_pkg::drp_req_t req,
  input  drp_pkg::drp_rsp_t rsp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD,
    S_RD_WAIT,
    S_WR,
    S_WR_WAIT,
    S_REL
  } state_t;

  state_t            state;
  logic              pend;
  ui_pkg::setting_t  set_q;
  drp_pkg::div_reg_t rd_word;
  drp_pkg::div_reg_t merged;
  drp_pkg::div_reg_t wr_word;
  logic [5:0]        div_d;

  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      state <= S_IDLE;
      pend  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (change || pend) begin
            state <= S_RD;
            pend  <= 1'b0;
          end
        end
        S_RD: state <= S_RD_WAIT;
        S_RD_WAIT: begin
          if (rsp.rdy) begin
            state <= S_WR;
          end
        end
        S_WR: state <= S_WR_WAIT;
        S_WR_WAIT: begin
          if (rsp.rdy) begin
            state <= S_REL;
          end
        end
        S_REL: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
      // A change during a sequence runs once more afterwards.
      if (change && state != S_IDLE) begin
        pend <= 1'b1;
      end
    end
  end

  // Setting d = s + 1, split into high and low counts.
  always_comb begin
    rd_word     = rsp.rdata;
    div_d       = 6'(set_q) + 6'd1;
    merged.rsvd = rd_word.rsvd;
    merged.hi   = (div_d + 6'd1) >> 1;
    merged.lo   = div_d >> 1;
  end

  always_ff @(posedge clkp) begin
    if (state == S_IDLE) begin
      set_q <= setting;
    end
    if (state == S_RD_WAIT && rsp.rdy) begin
      wr_word <= merged;
    end
  end

  // PLL stays in reset for the whole sequence.
  always_comb begin
    req.en      = (state == S_RD) || (state == S_WR);
    req.we      = (state == S_WR);
    req.addr    = `DRP_DIV_ADDR;
    req.wdata   = wr_word;
    req.rst_pll = (state != S_IDLE);
  end

endmodule

/* pll_model.sv */
`include "pll_ctrl_defines.svh"

module pll_model (
  input  logic              clkp,
  input  logic              rstxo,
  input  drp_pkg::drp_req_t req,
  output drp_pkg::drp_rsp_t rsp,
  output logic              tick
);

  localparam int                LOCK_W    = $clog2(`LOCK_CYCLES);
  localparam logic [LOCK_W-1:0] LOCK_LAST = LOCK_W'(`LOCK_CYCLES - 1);

  logic [`DRP_LAT-1:0]    lat_sr;
  logic                   op_we;
  logic [`DRP_ADDR_W-1:0] op_addr;
  drp_pkg::div_reg_t      op_wdata;
  logic                   hit;
  drp_pkg::div_reg_t      div_q;
  logic [LOCK_W-1:0]      lock_cnt;
  logic                   locked;
  logic [6:0]             div_d;
  logic [6:0]             tick_cnt;
  logic [6:0]             tick_cnt_inc;

  // Latch the access, answer DRP_LAT cycles after en.
  always_ff @(posedge clkp) begin
    if (req.en) begin
      op_we    <= req.we;
      op_addr  <= req.addr;
      op_wdata <= req.wdata;
    end
  end

  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      lat_sr <= '0;
    end else begin
      lat_sr <= {lat_sr[`DRP_LAT-2:0], req.en};
    end
  end

  assign hit = (op_addr == `DRP_DIV_ADDR);

  // Reset value gives d = 1.
  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      div_q <= '{rsvd: 4'hA, lo: 6'd0, hi: 6'd1};
    end else if (lat_sr[`DRP_LAT-1] && op_we && hit) begin
      div_q <= op_wdata;
    end
  end

  always_comb begin
    rsp.rdy    = lat_sr[`DRP_LAT-1];
    rsp.rdata  = (hit && !op_we) ? div_q : '0;
    rsp.locked = locked;
  end

  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      lock_cnt <= '0;
      locked   <= 1'b0;
    end else if (req.rst_pll) begin
      lock_cnt <= '0;
      locked   <= 1'b0;
    end else if (!locked) begin
      if (lock_cnt == LOCK_LAST) begin
        locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    div_d        = 7'(div_q.hi) + 7'(div_q.lo);
    tick_cnt_inc = tick_cnt + 7'd1;
  end

  // One tick every d cycles while locked.
  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else if (!locked || req.rst_pll) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else if (tick_cnt_inc >= div_d) begin
      tick_cnt <= '0;
      tick     <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt_inc;
      tick     <= 1'b0;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_pll_ctrl -f list.f

./obj_dir/Vtb_pll_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation did not pass, see sim.log."
  exit 1
fi

/* setting_ctrl.sv */
module setting_ctrl (
  input  logic             clkp,
  input  logic             rstxp,
  input  logic             btn_up,
  input  logic             btn_dn,
  output logic             rstxo,
  output ui_pkg::setting_t setting,
  output logic             change,
  output ui_pkg::digits_t  digits
);

  logic             rstx_d1;
  logic             btn_up_d1;
  logic             btn_dn_d1;
  logic             up_fall;
  logic             dn_fall;
  ui_pkg::setting_t ones;

  function automatic ui_pkg::seg_t seg_decode(input ui_pkg::setting_t d);
    ui_pkg::seg_t seg;
    case (d)
      4'd0:    seg = 7'b1000000;
      4'd1:    seg = 7'b1111001;
      4'd2:    seg = 7'b0100100;
      4'd3:    seg = 7'b0110000;
      4'd4:    seg = 7'b0011001;
      4'd5:    seg = 7'b0010010;
      4'd6:    seg = 7'b0000010;
      4'd7:    seg = 7'b1111000;
      4'd8:    seg = 7'b0000000;
      4'd9:    seg = 7'b0010000;
      default: seg = 7'b1111111;
    endcase
    return seg;
  endfunction

  // Reset release, two flops.
  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      rstx_d1 <= 1'b0;
      rstxo   <= 1'b0;
    end else begin
      rstx_d1 <= 1'b1;
      rstxo   <= rstx_d1;
    end
  end

  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      btn_up_d1 <= 1'b0;
      btn_dn_d1 <= 1'b0;
    end else begin
      btn_up_d1 <= btn_up;
      btn_dn_d1 <= btn_dn;
    end
  end

  // Release of a button.
  assign up_fall = btn_up_d1 & ~btn_up;
  assign dn_fall = btn_dn_d1 & ~btn_dn;

  // Down has priority, both directions wrap.
  always_ff @(posedge clkp or negedge rstxo) begin
    if (!rstxo) begin
      setting <= '0;
      change  <= 1'b0;
    end else begin
      if (dn_fall) begin
        setting <= setting - 1'b1;
      end else if (up_fall) begin
        setting <= setting + 1'b1;
      end
      change <= up_fall | dn_fall;
    end
  end

  // Tens digit is blank below 10.
  always_comb begin
    if (setting >= 4'd10) begin
      ones          = setting - 4'd10;
      digits.digit1 = seg_decode(4'd1);
    end else begin
      ones          = setting;
      digits.digit1 = 7'b1111111;
    end
    digits.digit0 = seg_decode(ones);
  end

endmodule

/* tb_pll_ctrl.sv */
`include "pll_ctrl_defines.svh"

module tb_pll_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TIMEOUT_CYCLES = 20000;
  localparam int unsigned SEED           = 32'h55bb;
  localparam int          RELOCK_LIMIT   = 2 * `DRP_LAT + `LOCK_CYCLES + 10;

  // Active-low segments in gfedcba order.
  localparam logic [6:0] SEG_TAB [0:9] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
  };
  localparam logic [6:0]      SEG_BLANK   = 7'h7f;
  localparam ui_pkg::digits_t DIGITS_ZERO = '{digit1: 7'h7f, digit0: 7'h40};

  logic             clkp;
  logic             rstxp;
  logic             btn_up;
  logic             btn_dn;
  ui_pkg::digits_t  digits;
  logic             pll_lock;
  logic             div32;
  logic             rstxo;

  ui_pkg::setting_t exp_set;
  int               cyc          = 0;
  int               since_change = 1000;
  ui_pkg::digits_t  digits_q     = DIGITS_ZERO;

  pll_ctrl_top uut (
    .clkp     (clkp),
    .rstxp    (rstxp),
    .btn_up   (btn_up),
    .btn_dn   (btn_dn),
    .digits   (digits),
    .pll_lock (pll_lock),
    .div32    (div32),
    .rstxo    (rstxo)
  );

  initial begin
    clkp = 1'b0;
    forever #2 clkp = ~clkp;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  function automatic ui_pkg::digits_t expected_digits(input ui_pkg::setting_t s);
    ui_pkg::digits_t d;
    int              v;
    v = int'(s);
    d.digit1 = (v >= 10) ? SEG_TAB[1] : SEG_BLANK;
    d.digit0 = SEG_TAB[v % 10];
    return d;
  endfunction

  always @(posedge clkp) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: the run did not finish within %0d cycles", cyc));
    end
  end

  // Cycles since the display last changed.
  always @(posedge clkp) begin
    digits_q <= digits;
    if (digits != digits_q) begin
      since_change <= 0;
    end else if (since_change < 1000) begin
      since_change <= since_change + 1;
    end
  end

  assert property (@(posedge clkp)
    !rstxp |-> (!rstxo && !div32 && !pll_lock && digits == DIGITS_ZERO))
    else report_failure($sformatf(
      "Error at %0t ns: rstxo = %b, div32 = %b, pll_lock = %b, digits = %h in reset, %s",
      $time, rstxo, div32, pll_lock, digits, "expected 0, 0, 0, 3fc0"));

  // Lock only drops right after a setting change.
  assert property (@(posedge clkp) disable iff (!rstxo)
    $fell(pll_lock) |-> since_change <= 3)
    else report_failure($sformatf(
      "pll_lock fell at %0t ns without a setting change just before it", $time));

  assert property (@(posedge clkp) disable iff (!rstxo)
    $rose(pll_lock) |-> since_change >= `LOCK_CYCLES)
    else report_failure($sformatf(
      "pll_lock rose at %0t ns sooner than a full lock delay after a change", $time));

  task automatic next_cycle();
    @(posedge clkp);
    #1;
  endtask

  task automatic press_button(input logic up_dir, input int hold);
    if (up_dir) begin
      btn_up = 1'b1;
    end else begin
      btn_dn = 1'b1;
    end
    repeat (hold) next_cycle();
    btn_up = 1'b0;
    btn_dn = 1'b0;
    // The release is sampled at this edge.
    next_cycle();
    exp_set = up_dir ? exp_set + 1'b1 : exp_set - 1'b1;
    assert (digits == expected_digits(exp_set))
      else report_failure($sformatf("Error at %0t ns: digits = %h, expected %h",
        $time, digits, expected_digits(exp_set)));
  endtask

  task automatic expect_lock_drop(output int waited);
    int n;
    n = 0;
    while (pll_lock && n < 3) begin
      next_cycle();
      n++;
    end
    assert (!pll_lock)
      else report_failure("pll_lock stayed high for more than 3 cycles after a change");
    waited = n;
  endtask

  task automatic wait_for_lock(input int limit);
    int n;
    n = 0;
    while (!pll_lock && n < limit) begin
      next_cycle();
      n++;
    end
    assert (pll_lock)
      else report_failure($sformatf("pll_lock did not rise within %0d cycles", limit));
  endtask

  task automatic press_and_relock(input logic up_dir);
    int waited;
    press_button(up_dir, 3);
    expect_lock_drop(waited);
    wait_for_lock(RELOCK_LIMIT - waited);
    repeat ($urandom_range(6, 1)) next_cycle();
  endtask

  task automatic wait_div32_toggle(output int at_cycle);
    logic last;
    last = div32;
    do begin
      next_cycle();
    end while (div32 == last);
    at_cycle = cyc;
  endtask

  // The first toggle only aligns the measurement.
  task automatic measure_div32();
    int t0;
    int t1;
    int want;
    want = 16 * (int'(exp_set) + 1);
    wait_div32_toggle(t0);
    wait_div32_toggle(t1);
    assert (t1 - t0 == want)
      else report_failure($sformatf("Error at %0t ns: div32 phase = %0d cycles, expected %0d",
        $time, t1 - t0, want));
  endtask

  initial begin
    ui_pkg::setting_t target;
    logic             dir;
    int               waited;
    rstxp   = 1'b1;
    btn_up  = 1'b0;
    btn_dn  = 1'b0;
    exp_set = '0;
    void'($urandom(SEED));
    #1;
    rstxp = 1'b0;
    repeat (3) @(posedge clkp);
    #1;
    rstxp = 1'b1;
    next_cycle();
    assert (!rstxo)
      else report_failure($sformatf("Error at %0t ns: rstxo = %b, expected 0", $time, rstxo));
    next_cycle();
    assert (rstxo)
      else report_failure($sformatf("Error at %0t ns: rstxo = %b, expected 1", $time, rstxo));
    wait_for_lock(`LOCK_CYCLES + 5);
    measure_div32();

    // Full wrap upward with the divider checked at 15.
    repeat (16) begin
      press_and_relock(1'b1);
      if (exp_set == 4'd15) begin
        measure_div32();
      end
    end

    repeat (4) press_and_relock(1'b0);

    repeat (3) begin
      target = ui_pkg::setting_t'($urandom_range(14, 1));
      while (exp_set != target) begin
        press_and_relock(1'b1);
      end
      measure_div32();
    end

    // Burst of presses while a sequence is running.
    press_button(1'b1, 2);
    expect_lock_drop(waited);
    repeat (4) begin
      repeat ($urandom_range(2, 1)) next_cycle();
      dir = 1'($urandom_range(1, 0));
      press_button(dir, 2);
    end
    wait_for_lock(2 * RELOCK_LIMIT);
    measure_div32();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* ui_pkg.sv */
`include "pll_ctrl_defines.svh"

package ui_pkg;

  typedef logic [`SETTING_W-1:0] setting_t;

  // Segments gfedcba, active low.
  typedef logic [6:0] seg_t;

  typedef struct packed {
    seg_t digit1;
    seg_t digit0;
  } digits_t;

endpackage
